/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --timescale 1ns/10ps
TOP       = tb_can_rx
FILELIST  = vlog.f

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '=== PASS ==='

clean:
	rm -rf obj_dir

/* can_acceptance_filter.sv */
`timescale 1ns/10ps
module can_acceptance_filter import can_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              filt_wr,
  input  logic [1:0]        filt_reg,     // 0 code hi, 1 code lo, 2 mask hi, 3 mask lo
  input  logic [DATA_W-1:0] wr_data,
  input  can_id_t           rx_id,
  output logic              hit
);

  can_id_t code, mask;                     // mask bit 1 means don't care

  assign hit = &(~(rx_id ^ code) | mask);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      code <= '0;
      mask <= '0;
    end else if (filt_wr) begin
      case (filt_reg)
        2'd0: code[10:3] <= wr_data;
        2'd1: code[2:0]  <= wr_data[7:5];   // low id bits sit at the top of the byte
        2'd2: mask[10:3] <= wr_data;
        2'd3: mask[2:0]  <= wr_data[7:5];
      endcase
    end
  end

endmodule

/* can_bit_timing.sv */
`timescale 1ns/10ps
module can_bit_timing import can_pkg::*; #(
  parameter int TQ_PER_BIT = 10,
  parameter int SAMPLE_TQ  = 7
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              reset_mode,
  input  logic [DATA_W-1:0] div_factor,   // clocks per quantum minus one
  input  logic              rxd,
  output logic              rx_bit,
  output logic              sample
);

  localparam int TQ_W = $clog2(TQ_PER_BIT);

  logic              rxd_meta, rxd_sync, rxd_prev;
  logic [DATA_W-1:0] presc_cnt;
  logic [TQ_W-1:0]   tq_cnt;
  logic              fall;                   // recessive to dominant edge

  assign fall = rxd_prev && !rxd_sync;

  always_ff @(posedge clk) begin
    sample <= 1'b0;
    if (!rst_n) begin
      rxd_meta  <= 1'b1;                     // bus is recessive at rest
      rxd_sync  <= 1'b1;
      rxd_prev  <= 1'b1;
      presc_cnt <= '0;
      tq_cnt    <= '0;
      rx_bit    <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
      if (fall) begin                        // hard resync, bit restarts at quantum 0
        presc_cnt <= '0;
        tq_cnt    <= '0;
      end else if (presc_cnt == div_factor) begin
        presc_cnt <= '0;
        tq_cnt    <= (tq_cnt == TQ_W'(TQ_PER_BIT - 1)) ? '0 : tq_cnt + 1'b1;
      end else begin
        presc_cnt <= presc_cnt + 1'b1;
      end
      if (!fall && !reset_mode && presc_cnt == '0 && tq_cnt == TQ_W'(SAMPLE_TQ)) begin
        sample <= 1'b1;                      // first clock of the sample quantum
        rx_bit <= rxd_sync;
      end
    end
  end

endmodule

/* can_destuff_crc.sv */
`timescale 1ns/10ps
module can_destuff_crc import can_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic in_frame,
  input  logic sample,
  input  logic rx_bit,
  output logic bit_valid,
  output logic data_bit,
  output logic stuff_err,
  output logic crc_zero
);

  logic [2:0]       run_cnt;                  // length of the current run of equal bits
  logic             last_bit;
  logic [CRC_W-1:0] crc;

  function automatic logic [CRC_W-1:0] crc_step(input logic [CRC_W-1:0] cur, input logic b);
    logic fb;
    fb = b ^ cur[CRC_W-1];
    crc_step = {cur[CRC_W-2:0], 1'b0} ^ (fb ? CRC_POLY : '0);
  endfunction

  assign crc_zero = (crc == '0);             // received crc folded in gives zero remainder

  always_ff @(posedge clk) begin
    bit_valid <= 1'b0;
    stuff_err <= 1'b0;
    if (!rst_n) begin
      run_cnt  <= '0;
      last_bit <= 1'b1;
      crc      <= '0;
      data_bit <= 1'b1;
    end else if (sample) begin
      if (!in_frame) begin                   // possible sof, start a fresh frame
        run_cnt   <= 3'd1;
        last_bit  <= rx_bit;
        crc       <= crc_step('0, rx_bit);
        data_bit  <= rx_bit;
        bit_valid <= 1'b1;
      end else if (run_cnt == 3'(STUFF_LEN)) begin
        stuff_err <= (rx_bit == last_bit);   // stuff bit must be the opposite level
        run_cnt   <= 3'd1;
        last_bit  <= rx_bit;
      end else begin
        run_cnt   <= (rx_bit == last_bit) ? run_cnt + 3'd1 : 3'd1;
        last_bit  <= rx_bit;
        crc       <= crc_step(crc, rx_bit);
        data_bit  <= rx_bit;
        bit_valid <= 1'b1;
      end
    end else if (!in_frame) begin
      run_cnt <= '0;
      crc     <= '0;
    end
  end

endmodule

/* can_frame_rx.sv */
`timescale 1ns/10ps
module can_frame_rx import can_pkg::*; (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            reset_mode,
  input  logic                            rx_bit,
  input  logic                            sample,
  input  logic                            bit_valid,
  input  logic                            data_bit,
  input  logic                            stuff_err,
  input  logic                            crc_zero,
  output logic                            in_frame,
  output can_id_t                         rx_id,
  output logic                            rx_rtr,
  output logic [3:0]                      rx_dlc,
  output logic [MAX_DATA-1:0][DATA_W-1:0] rx_data,
  output logic                            frame_ok,
  output logic                            frame_crc_err
);

  rx_state_t  state;
  logic [5:0] bit_cnt;                       // bit position inside the field
  logic [3:0] idle_cnt;                      // recessive samples while waiting for idle
  logic       crc_ok;                        // remainder after the last crc bit
  logic [2:0] byte_last;                     // last data byte, dlc above 8 means 8

  assign in_frame  = (state != ST_IDLE) && (state != ST_WAIT_IDLE);
  assign byte_last = (rx_dlc > 4'd8) ? 3'd7 : 3'(rx_dlc - 4'd1);

  always_ff @(posedge clk) begin
    frame_ok      <= 1'b0;
    frame_crc_err <= 1'b0;
    if (!rst_n || reset_mode) begin
      state    <= ST_IDLE;
      bit_cnt  <= '0;
      idle_cnt <= '0;
      crc_ok   <= 1'b0;
    end else if (state == ST_IDLE) begin
      if (sample && !rx_bit)
        state <= ST_SOF;                     // dominant bit on an idle bus
    end else if (state == ST_WAIT_IDLE) begin
      if (sample) begin
        idle_cnt <= rx_bit ? idle_cnt + 4'd1 : '0;
        if (rx_bit && idle_cnt == 4'(IDLE_BITS - 1)) begin
          state    <= ST_IDLE;
          idle_cnt <= '0;                    // next wait starts a fresh count
        end
      end
    end else if (stuff_err) begin
      state <= ST_WAIT_IDLE;
    end else if (bit_valid) begin
      bit_cnt <= bit_cnt + 6'd1;
      case (state)
        ST_SOF: begin
          state   <= ST_ID;
          bit_cnt <= '0;
        end
        ST_ID:   if (bit_cnt == 6'd10) state <= ST_RTR;
        ST_RTR:  state <= ST_IDE;
        ST_IDE:  state <= data_bit ? ST_WAIT_IDLE : ST_R0;  // extended frame, skip it
        ST_R0: begin
          state   <= ST_DLC;
          bit_cnt <= '0;
        end
        ST_DLC: if (bit_cnt == 6'd3) begin
          bit_cnt <= '0;
          state   <= (rx_rtr || {rx_dlc[2:0], data_bit} == 4'd0) ? ST_CRC : ST_DATA;
        end
        ST_DATA: if (bit_cnt == {byte_last, 3'b111}) begin
          state   <= ST_CRC;
          bit_cnt <= '0;
        end
        ST_CRC: begin
          crc_ok <= crc_zero;                // already includes this bit
          if (bit_cnt == 6'(CRC_W - 1)) state <= ST_CRC_DELIM;
        end
        ST_CRC_DELIM: begin                  // dominant delimiter is a form error
          state         <= ST_WAIT_IDLE;
          frame_ok      <= data_bit && crc_ok;
          frame_crc_err <= data_bit && !crc_ok;
        end
        default: state <= ST_WAIT_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin             // field shift registers, msb first
    if (bit_valid) begin
      case (state)
        ST_ID:   rx_id <= {rx_id[9:0], data_bit};
        ST_RTR:  rx_rtr <= data_bit;
        ST_DLC:  rx_dlc <= {rx_dlc[2:0], data_bit};
        ST_DATA: rx_data[bit_cnt[5:3]][3'd7 - bit_cnt[2:0]] <= data_bit;
        default: ;
      endcase
    end
  end

endmodule

/* can_host_regs.sv */
`timescale 1ns/10ps
module can_host_regs import can_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [ADR_W-1:0]  adr,
  input  logic [DATA_W-1:0] datain,
  input  logic              cs_b,
  input  logic              rd_b,
  input  logic              wr_b,
  input  logic              buf_full,
  input  logic              overrun,
  input  logic              crc_err,
  input  logic              in_frame,
  input  logic [DATA_W-1:0] rd_byte,
  output logic [DATA_W-1:0] dataout,
  output logic              irq,
  output logic              reset_mode,
  output logic [DATA_W-1:0] div_factor,
  output logic [2:0]        filt_wr,      // one strobe per filter
  output logic [1:0]        filt_reg,
  output logic [DATA_W-1:0] wr_data,
  output logic              release_buf,
  output logic              clr_ovr,
  output logic              clr_crc,
  output logic [3:0]        buf_index
);

  logic              wr, rd, cmd_wr, filt_adr, buf_adr;
  logic              rie;                  // receive interrupt enable
  logic [ADR_W-1:0]  filt_off;
  logic [DATA_W-1:0] rd_mux;

  assign wr       = !cs_b && !wr_b;
  assign rd       = !cs_b && !rd_b;
  assign cmd_wr   = wr && (adr == ADR_CMD);
  assign filt_off = adr - ADR_FILT_BASE;
  assign filt_adr = (adr >= ADR_FILT_BASE) && (adr < ADR_RXBUF_BASE);
  assign buf_adr  = (adr >= ADR_RXBUF_BASE) && (adr < ADR_RXBUF_BASE + ADR_W'(RXBUF_LEN));

  assign filt_wr     = (wr && reset_mode && filt_adr) ? 3'b001 << filt_off[3:2] : 3'b000;
  assign filt_reg    = filt_off[1:0];
  assign wr_data     = datain;
  assign release_buf = cmd_wr && datain[CMD_RELEASE];
  assign clr_ovr     = cmd_wr && datain[CMD_CLR_OVR];
  assign clr_crc     = cmd_wr && datain[CMD_CLR_CRC];
  assign buf_index   = 4'(adr - ADR_RXBUF_BASE);

  always_comb begin
    rd_mux = '0;                           // filters and holes read 0
    if (adr == ADR_CTRL)
      rd_mux = DATA_W'({rie, reset_mode});
    else if (adr == ADR_STATUS)
      rd_mux = DATA_W'({in_frame, crc_err, overrun, buf_full});
    else if (adr == ADR_PRESC)
      rd_mux = div_factor;
    else if (buf_adr)
      rd_mux = rd_byte;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reset_mode <= 1'b1;                  // node starts held in reset mode
      rie        <= 1'b0;
      div_factor <= '0;
      dataout    <= '0;
      irq        <= 1'b0;
    end else begin
      irq <= rie && buf_full;
      if (wr && adr == ADR_CTRL) begin
        reset_mode <= datain[0];
        rie        <= datain[1];
      end
      if (wr && reset_mode && adr == ADR_PRESC)
        div_factor <= datain;              // bit timing locked outside reset mode
      if (rd)
        dataout <= rd_mux;                 // held until the next read
    end
  end

endmodule

/* can_pkg.sv */
package can_pkg;

  typedef logic [10:0] can_id_t;                      // standard format identifier

  localparam int DATA_W    = 8;                       // host data bus
  localparam int ADR_W     = 6;                       // host address bus
  localparam int MAX_DATA  = 8;                       // data bytes per frame
  localparam int CRC_W     = 15;
  localparam logic [CRC_W-1:0] CRC_POLY = 15'h4599;  // x15+x14+x10+x8+x7+x4+x3+1
  localparam int STUFF_LEN = 5;                       // equal bits before a stuff bit
  localparam int IDLE_BITS = 11;                      // recessive bits meaning bus idle
  localparam int RXBUF_LEN = 11;                      // id hi, id lo/rtr/dlc, 8 data, filter

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_SOF,
    ST_ID,
    ST_RTR,
    ST_IDE,
    ST_R0,
    ST_DLC,
    ST_DATA,
    ST_CRC,
    ST_CRC_DELIM,
    ST_WAIT_IDLE                                      // error or end of frame, wait for idle
  } rx_state_t;

  typedef enum int {
    CMD_RELEASE = 0,                                  // free the receive buffer
    CMD_CLR_OVR = 1,
    CMD_CLR_CRC = 2
  } cmd_bit_t;

  localparam logic [ADR_W-1:0] ADR_CTRL       = 6'd0;  // bit0 reset mode, bit1 rie
  localparam logic [ADR_W-1:0] ADR_CMD        = 6'd1;  // write side
  localparam logic [ADR_W-1:0] ADR_STATUS     = 6'd1;  // read side
  localparam logic [ADR_W-1:0] ADR_PRESC      = 6'd2;
  localparam logic [ADR_W-1:0] ADR_FILT_BASE  = 6'd4;  // 4 bytes per filter
  localparam logic [ADR_W-1:0] ADR_RXBUF_BASE = 6'd16;

endpackage

/* can_rx_buffer.sv */
`timescale 1ns/10ps
module can_rx_buffer import can_pkg::*; #(
  parameter int NUM_FILT = 3
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            reset_mode,
  input  logic [NUM_FILT-1:0]             hit,
  input  logic                            frame_ok,
  input  logic                            frame_crc_err,
  input  can_id_t                         rx_id,
  input  logic                            rx_rtr,
  input  logic [3:0]                      rx_dlc,
  input  logic [MAX_DATA-1:0][DATA_W-1:0] rx_data,
  input  logic                            release_buf,
  input  logic                            clr_ovr,
  input  logic                            clr_crc,
  input  logic [3:0]                      buf_index,
  output logic [DATA_W-1:0]               rd_byte,
  output logic                            buf_full,
  output logic                            overrun,
  output logic                            crc_err
);

  localparam int IDX_W = (NUM_FILT > 1) ? $clog2(NUM_FILT) : 1;

  can_id_t                         buf_id;
  logic                            buf_rtr;
  logic [3:0]                      buf_dlc;
  logic [MAX_DATA-1:0][DATA_W-1:0] buf_data;
  logic [IDX_W-1:0]                buf_filt, hit_idx;
  logic                            accept;
  logic [3:0]                      data_len, data_idx;

  assign accept   = frame_ok && (|hit);
  assign data_len = (buf_dlc > 4'd8) ? 4'd8 : buf_dlc;
  assign data_idx = buf_index - 4'd2;        // data bytes start at offset 2

  always_comb begin                          // lowest accepting filter wins
    hit_idx = '0;
    for (int i = NUM_FILT - 1; i >= 0; i--)
      if (hit[i]) hit_idx = IDX_W'(i);
  end

  always_ff @(posedge clk) begin
    if (!rst_n || reset_mode) begin
      buf_full <= 1'b0;
      overrun  <= 1'b0;
      crc_err  <= 1'b0;
    end else begin
      if (release_buf) buf_full <= 1'b0;
      if (clr_ovr)     overrun  <= 1'b0;
      if (clr_crc)     crc_err  <= 1'b0;
      if (accept && buf_full) overrun <= 1'b1;  // new message lost, old one kept
      if (accept && !buf_full) buf_full <= 1'b1;
      if (frame_crc_err) crc_err <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (accept && !buf_full) begin
      buf_id   <= rx_id;
      buf_rtr  <= rx_rtr;
      buf_dlc  <= rx_dlc;
      buf_data <= rx_data;
      buf_filt <= hit_idx;
    end
  end

  always_comb begin
    rd_byte = '0;
    case (buf_index)
      4'd0:  rd_byte = buf_id[10:3];
      4'd1:  rd_byte = {buf_id[2:0], buf_rtr, buf_dlc};
      4'd10: rd_byte = DATA_W'(buf_filt);
      default:
        if (buf_index < 4'd10 && !buf_rtr && data_idx < data_len)
          rd_byte = buf_data[data_idx[2:0]];  // bytes past the dlc stay 0
    endcase
  end

endmodule

/* can_rx_checker.sv */
`timescale 1ns/10ps
module can_rx_checker import can_pkg::*; #(
  parameter int NUM_FILT = 3
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [ADR_W-1:0]  adr,
  input  logic [DATA_W-1:0] datain,
  input  logic              cs_b,
  input  logic              rd_b,
  input  logic              wr_b,
  input  logic [DATA_W-1:0] dataout,
  input  logic              irq,
  input  logic              note,            // one cycle, a frame has gone out on rxd
  input  can_id_t           note_id,
  input  logic              note_rtr,
  input  logic [3:0]        note_dlc,
  input  logic [63:0]       note_data,       // byte 0 in bits 63:56
  input  logic [1:0]        note_kind,       // 0 good, 1 bad crc, 2 extended
  output int                checks,
  output int                errors
);

  logic              rm, rie, full, ovr, crc_e;     // model of control and status
  logic [DATA_W-1:0] presc;
  can_id_t           code [NUM_FILT];
  can_id_t           mask [NUM_FILT];
  logic [DATA_W-1:0] rxbuf [RXBUF_LEN];             // stored message image
  logic [DATA_W-1:0] exp_data, last_data;
  logic [ADR_W-1:0]  exp_adr;
  logic              exp_irq;
  logic              pend = 1'b0;
  logic              live = 1'b0;

  function automatic logic [DATA_W-1:0] ref_read(input logic [ADR_W-1:0] a);
    if (a == ADR_CTRL) return DATA_W'({rie, rm});
    if (a == ADR_STATUS) return DATA_W'({1'b0, crc_e, ovr, full});  // idle bus after frame
    if (a == ADR_PRESC) return presc;
    if (a >= ADR_RXBUF_BASE && int'(a) < int'(ADR_RXBUF_BASE) + RXBUF_LEN)
      return rxbuf[int'(a) - int'(ADR_RXBUF_BASE)];
    return '0;                                      // filters and holes
  endfunction

  task automatic host_write(input logic [ADR_W-1:0] a, input logic [DATA_W-1:0] d);
    int off;
    off = int'(a) - int'(ADR_FILT_BASE);
    if (a == ADR_CTRL) begin
      rm  = d[0];
      rie = d[1];
      if (d[0]) begin                               // reset mode drops all status
        full  = 1'b0;
        ovr   = 1'b0;
        crc_e = 1'b0;
      end
    end else if (a == ADR_CMD) begin
      if (d[CMD_RELEASE]) full  = 1'b0;
      if (d[CMD_CLR_OVR]) ovr   = 1'b0;
      if (d[CMD_CLR_CRC]) crc_e = 1'b0;
    end else if (a == ADR_PRESC && rm) begin
      presc = d;
    end else if (a >= ADR_FILT_BASE && a < ADR_RXBUF_BASE && rm && off / 4 < NUM_FILT) begin
      case (off % 4)
        0: code[off / 4][10:3] = d;
        1: code[off / 4][2:0]  = d[7:5];
        2: mask[off / 4][10:3] = d;
        default: mask[off / 4][2:0] = d[7:5];
      endcase
    end
  endtask

  task automatic take_frame();
    int hit_f, nbytes;
    hit_f  = -1;
    nbytes = (note_dlc > 4'd8) ? 8 : int'(note_dlc);
    if (rm || note_kind == 2'd2) return;           // extended frames are ignored
    if (note_kind == 2'd1) begin
      crc_e = 1'b1;
      return;
    end
    for (int f = NUM_FILT - 1; f >= 0; f--)        // lowest matching filter wins
      if (((note_id ^ code[f]) & ~mask[f]) == '0) hit_f = f;
    if (hit_f < 0) return;
    if (full) begin
      ovr = 1'b1;                                   // old message kept
      return;
    end
    rxbuf[0] = note_id[10:3];
    rxbuf[1] = {note_id[2:0], note_rtr, note_dlc};
    for (int k = 0; k < MAX_DATA; k++)
      rxbuf[2 + k] = (!note_rtr && k < nbytes) ? note_data[63 - 8 * k -: 8] : 8'h00;
    rxbuf[10] = 8'(hit_f);
    full = 1'b1;
  endtask

  always @(posedge clk) begin
    live = rst_n;
    if (!rst_n) begin
      rm        = 1'b1;
      rie       = 1'b0;
      presc     = '0;
      full      = 1'b0;
      ovr       = 1'b0;
      crc_e     = 1'b0;
      pend      = 1'b0;
      last_data = '0;
      for (int f = 0; f < NUM_FILT; f++) begin
        code[f] = '0;
        mask[f] = '0;
      end
    end else begin
      pend = !cs_b && !rd_b;
      if (pend) begin
        exp_data = ref_read(adr);
        exp_adr  = adr;
        exp_irq  = rie && full;                     // irq is a registered copy
      end
      if (!cs_b && !wr_b) host_write(adr, datain);
      if (note) take_frame();
    end
  end

  always @(negedge clk) begin                       // outputs settled since the posedge
    if (live && pend) begin
      checks++;
      if (dataout !== exp_data) begin
        $display("FAILED %0d ns dataout at adr %0d: got %02h expected %02h",
                 $time, exp_adr, dataout, exp_data);
        errors++;
      end
      if (irq !== exp_irq) begin
        $display("FAILED %0d ns irq: got %b expected %b", $time, irq, exp_irq);
        errors++;
      end
      last_data = exp_data;
    end else if (live && dataout !== last_data) begin
      $display("FAILED %0d ns dataout held: got %02h expected %02h",
               $time, dataout, last_data);
      errors++;
      last_data = dataout;                          // report each change once
    end
  end

endmodule

/* can_rx_top.sv */
`timescale 1ns/10ps
module can_rx_top import can_pkg::*; #(
  parameter int NUM_FILT   = 3,
  parameter int TQ_PER_BIT = 10,
  parameter int SAMPLE_TQ  = 7
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [ADR_W-1:0]  adr,
  input  logic [DATA_W-1:0] datain,
  input  logic              cs_b,
  input  logic              rd_b,
  input  logic              wr_b,
  input  logic              rxd,
  output logic [DATA_W-1:0] dataout,
  output logic              irq
);

  logic                            reset_mode, release_buf, clr_ovr, clr_crc;
  logic [DATA_W-1:0]               div_factor, wr_data, rd_byte;
  logic [2:0]                      filt_wr;
  logic [1:0]                      filt_reg;
  logic [3:0]                      buf_index, rx_dlc;
  logic                            buf_full, overrun, crc_err;
  logic                            rx_bit, sample, bit_valid, data_bit, stuff_err, crc_zero;
  logic                            in_frame, rx_rtr, frame_ok, frame_crc_err;
  can_id_t                         rx_id;
  logic [MAX_DATA-1:0][DATA_W-1:0] rx_data;
  logic [NUM_FILT-1:0]             hit;

  can_host_regs i_can_host_regs (
    .clk, .rst_n, .adr, .datain, .cs_b, .rd_b, .wr_b,  // host bus
    .buf_full, .overrun, .crc_err, .in_frame,           // status sources
    .rd_byte,                                           // <- receive buffer
    .dataout, .irq,                                     // -> host
    .reset_mode, .div_factor,                           // -> datapath
    .filt_wr, .filt_reg, .wr_data,                      // -> filters
    .release_buf, .clr_ovr, .clr_crc, .buf_index        // -> receive buffer
  );

  can_bit_timing #(
    .TQ_PER_BIT (TQ_PER_BIT),
    .SAMPLE_TQ  (SAMPLE_TQ)
  ) i_can_bit_timing (
    .clk, .rst_n, .reset_mode, .div_factor,
    .rxd,                                               // from transceiver
    .rx_bit, .sample                                    // one sample per bit
  );

  can_destuff_crc i_can_destuff_crc (
    .clk, .rst_n, .in_frame, .sample, .rx_bit,
    .bit_valid, .data_bit, .stuff_err, .crc_zero
  );

  can_frame_rx i_can_frame_rx (
    .clk, .rst_n, .reset_mode, .rx_bit, .sample,
    .bit_valid, .data_bit, .stuff_err, .crc_zero,
    .in_frame,                                          // -> destuffer and status
    .rx_id, .rx_rtr, .rx_dlc, .rx_data,                 // assembled message
    .frame_ok, .frame_crc_err                           // outcome strobes
  );

  for (genvar i = 0; i < NUM_FILT; i++) begin : g_filt
    can_acceptance_filter i_can_acceptance_filter (
      .clk, .rst_n,
      .filt_wr  (filt_wr[i]),                           // own strobe, shared address
      .filt_reg, .wr_data, .rx_id,
      .hit      (hit[i])
    );
  end

  can_rx_buffer #(
    .NUM_FILT (NUM_FILT)
  ) i_can_rx_buffer (
    .clk, .rst_n, .reset_mode, .hit,
    .frame_ok, .frame_crc_err,
    .rx_id, .rx_rtr, .rx_dlc, .rx_data,
    .release_buf, .clr_ovr, .clr_crc, .buf_index,
    .rd_byte, .buf_full, .overrun, .crc_err
  );

endmodule

/* tb_can_rx.sv */
`timescale 1ns/10ps
module tb_can_rx import can_pkg::*; ();

  localparam int NUM_FILT    = 3;
  localparam int TQ_PER_BIT  = 10;
  localparam int SAMPLE_TQ   = 7;
  localparam int DIV         = 1;                        // two clocks per quantum
  localparam int BIT_CLKS    = (DIV + 1) * TQ_PER_BIT;
  localparam int CLK_NS      = 100;
  localparam int NUM_FRAMES  = 8;
  localparam int WATCHDOG_NS = NUM_FRAMES * 130 * BIT_CLKS * CLK_NS * 2;
  localparam logic [1:0] FRM_GOOD = 2'd0, FRM_BAD_CRC = 2'd1, FRM_EXT = 2'd2;

  logic              clk, rst_n, cs_b, rd_b, wr_b, rxd, irq;
  logic [ADR_W-1:0]  adr;
  logic [DATA_W-1:0] datain, dataout, rd;
  logic              note, note_rtr;                     // frame report to the checker
  can_id_t           note_id, id_a, id_b;
  logic [3:0]        note_dlc, dlc;
  logic [63:0]       note_data, data;
  logic [1:0]        note_kind;
  int                checks, errors, tb_errors, err_mark, test_no;
  integer            seed;

  can_rx_top #(
    .NUM_FILT   (NUM_FILT),
    .TQ_PER_BIT (TQ_PER_BIT),
    .SAMPLE_TQ  (SAMPLE_TQ)
  ) i_can_rx_top (
    .clk, .rst_n, .adr, .datain, .cs_b, .rd_b, .wr_b, .rxd, .dataout, .irq
  );

  can_rx_checker #(.NUM_FILT(NUM_FILT)) i_can_rx_checker (
    .clk, .rst_n, .adr, .datain, .cs_b, .rd_b, .wr_b, .dataout, .irq,
    .note, .note_id, .note_rtr, .note_dlc, .note_data, .note_kind,
    .checks, .errors
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the test sequence did not finish", WATCHDOG_NS);
    $display("=== FAIL ===");
    $finish;
  end

  task automatic write_reg(input logic [ADR_W-1:0] a, input logic [DATA_W-1:0] d);
    @(negedge clk);
    adr    = a;
    datain = d;
    cs_b   = 1'b0;
    wr_b   = 1'b0;                                       // one cycle strobe
    @(negedge clk);
    cs_b   = 1'b1;
    wr_b   = 1'b1;
  endtask

  task automatic read_reg(input logic [ADR_W-1:0] a, output logic [DATA_W-1:0] d);
    @(negedge clk);
    adr  = a;
    cs_b = 1'b0;
    rd_b = 1'b0;
    @(negedge clk);
    cs_b = 1'b1;
    rd_b = 1'b1;
    d    = dataout;                                      // registered on the strobe edge
  endtask

  task automatic read_rxbuf();
    logic [DATA_W-1:0] d;
    for (int i = 0; i < RXBUF_LEN; i++)
      read_reg(ADR_RXBUF_BASE + ADR_W'(i), d);
  endtask

  task automatic set_filter(input int f, input can_id_t code, input can_id_t mask);
    write_reg(ADR_FILT_BASE + ADR_W'(4 * f), code[10:3]);
    write_reg(ADR_FILT_BASE + ADR_W'(4 * f + 1), {code[2:0], 5'd0});
    write_reg(ADR_FILT_BASE + ADR_W'(4 * f + 2), mask[10:3]);
    write_reg(ADR_FILT_BASE + ADR_W'(4 * f + 3), {mask[2:0], 5'd0});
  endtask

  task automatic send_frame(input can_id_t id, input logic rtr, input logic [3:0] len,
                            input logic [63:0] payload, input logic [1:0] kind);
    bit               q[$];
    bit               s[$];
    logic [CRC_W-1:0] crc;
    logic             fb, last;
    int               run, nbytes;
    nbytes = (len > 4'd8) ? 8 : int'(len);
    q.push_back(1'b0);                                   // sof
    for (int i = 10; i >= 0; i--) q.push_back(id[i]);
    q.push_back(rtr);                                    // srr in an extended frame
    q.push_back(kind == FRM_EXT);                        // ide
    q.push_back(1'b0);                                   // r0
    for (int i = 3; i >= 0; i--) q.push_back(len[i]);
    if (!rtr)
      for (int i = 0; i < 8 * nbytes; i++) q.push_back(payload[63 - i]);
    crc = '0;
    foreach (q[i]) begin                                 // crc-15 over sof to data
      fb  = q[i] ^ crc[CRC_W-1];
      crc = {crc[CRC_W-2:0], 1'b0} ^ (fb ? CRC_POLY : 15'd0);
    end
    if (kind == FRM_BAD_CRC) crc[7] = ~crc[7];           // corrupt before stuffing
    for (int i = CRC_W - 1; i >= 0; i--) q.push_back(crc[i]);
    run  = 0;
    last = 1'b1;
    foreach (q[i]) begin
      s.push_back(q[i]);
      run  = (q[i] == last) ? run + 1 : 1;
      last = q[i];
      if (run == STUFF_LEN) begin                        // stuff bit opens a new run
        s.push_back(!last);
        last = !last;
        run  = 1;
      end
    end
    repeat (10 + IDLE_BITS) s.push_back(1'b1);           // crc delim, ack, eof, then idle
    foreach (s[i]) begin
      rxd = s[i];
      repeat (BIT_CLKS) @(negedge clk);
    end
    note_id   = id;
    note_rtr  = rtr;
    note_dlc  = len;
    note_data = payload;
    note_kind = kind;
    note      = 1'b1;
    @(negedge clk);
    note      = 1'b0;
  endtask

  task automatic wait_rx_done();
    logic [DATA_W-1:0] st;
    int                n;
    st = 8'hff;
    n  = 0;
    while (st[3] && n < 20) begin                        // status bit3 is receiving
      read_reg(ADR_STATUS, st);
      n++;
    end
    if (st[3]) begin
      $display("receiver still busy at %0d ns after the frame ended", $time);
      tb_errors++;
    end
  endtask

  task automatic end_test(input string name);
    int now_err;
    @(negedge clk);                                      // let the last compare settle
    now_err = errors + tb_errors - err_mark;
    if (now_err == 0)
      $display("test %0d %s: ok", test_no, name);
    else
      $display("test %0d %s: %0d error(s)", test_no, name, now_err);
    err_mark = errors + tb_errors;
    test_no++;
  endtask

  initial begin
    seed      = 32'h8fdb_43f0;
    rst_n     = 1'b0;
    cs_b      = 1'b1;
    rd_b      = 1'b1;
    wr_b      = 1'b1;
    adr       = '0;
    datain    = '0;
    rxd       = 1'b1;                                    // recessive idle bus
    note      = 1'b0;
    note_id   = '0;
    note_rtr  = 1'b0;
    note_dlc  = '0;
    note_data = '0;
    note_kind = FRM_GOOD;
    tb_errors = 0;
    err_mark  = 0;
    test_no   = 1;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    read_reg(ADR_STATUS, rd);
    read_reg(ADR_CTRL, rd);
    read_reg(ADR_PRESC, rd);
    end_test("reset values");

    id_a = 11'($random(seed));
    dlc  = 4'(($random(seed) & 7) + 1);
    data = {$random(seed), $random(seed)};
    write_reg(ADR_PRESC, DATA_W'(DIV));
    set_filter(0, id_a, 11'h000);
    set_filter(1, ~id_a, 11'h000);
    set_filter(2, ~id_a, 11'h000);
    write_reg(ADR_CTRL, 8'h02);                          // run mode, rie on
    send_frame(id_a, 1'b0, dlc, data, FRM_GOOD);
    wait_rx_done();
    read_rxbuf();
    read_reg(ADR_PRESC, rd);
    read_reg(ADR_FILT_BASE, rd);                         // no filter read-back
    read_reg(6'd3, rd);
    end_test("data frame through filter 0");

    id_b = 11'($random(seed));
    write_reg(ADR_CTRL, 8'h01);
    set_filter(0, ~id_b, 11'h000);
    set_filter(1, id_b ^ 11'h400, 11'h000);
    set_filter(2, id_b, 11'h00f);                        // low nibble don't care
    write_reg(ADR_CTRL, 8'h02);
    send_frame(id_b ^ 11'h005, 1'b0, 4'd8, {$random(seed), $random(seed)}, FRM_GOOD);
    wait_rx_done();
    read_rxbuf();
    write_reg(ADR_CMD, 8'h01);
    send_frame(id_b ^ 11'h100, 1'b1, 4'd2, 64'd0, FRM_GOOD);
    wait_rx_done();
    read_reg(ADR_STATUS, rd);
    end_test("filter 2 and remote frame without match");

    send_frame(id_b, 1'b0, 4'd5, {$random(seed), $random(seed)}, FRM_GOOD);
    wait_rx_done();
    send_frame(id_b ^ 11'h00a, 1'b0, 4'd1, {$random(seed), $random(seed)}, FRM_GOOD);
    wait_rx_done();
    read_rxbuf();                                        // first message still there
    write_reg(ADR_CMD, 8'h01);
    read_reg(ADR_STATUS, rd);
    write_reg(ADR_CMD, 8'h02);
    read_reg(ADR_STATUS, rd);
    end_test("overrun, release and clear overrun");

    send_frame(id_b, 1'b0, 4'd3, {$random(seed), $random(seed)}, FRM_BAD_CRC);
    wait_rx_done();
    read_rxbuf();                                        // old message, dlc 5, untouched
    send_frame(id_b, 1'b1, 4'd4, {$random(seed), $random(seed)}, FRM_EXT);
    wait_rx_done();
    write_reg(ADR_CMD, 8'h04);
    send_frame(id_b ^ 11'h003, 1'b0, 4'd12, {$random(seed), $random(seed)}, FRM_GOOD);
    wait_rx_done();
    read_rxbuf();
    end_test("crc error, extended frame, then valid frame");

    @(negedge clk);
    $display("tests %0d, reads checked %0d, errors %0d", test_no - 1, checks,
             errors + tb_errors);
    if (errors + tb_errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

/* vlog.f */
can_pkg.sv
can_bit_timing.sv
can_destuff_crc.sv
can_frame_rx.sv
can_acceptance_filter.sv
can_rx_buffer.sv
can_host_regs.sv
can_rx_top.sv
can_rx_checker.sv
tb_can_rx.sv
